//--- rtl/mem_pkg.sv
// ********************************************************************
// memory side definitions for the store streamer
// widths of the 64-bit memory port and the two-view address word
// ********************************************************************
`default_nettype none

package mem_pkg;

  localparam int unsigned ADDR_W   = 32;       // byte address
  localparam int unsigned MEM_DW   = 64;       // one memory word
  localparam int unsigned MEM_BE_W = MEM_DW/8; // byte enables

  // word index plus byte offset inside a 32-bit lane
  typedef struct packed {
    logic [ADDR_W-3:0] word_idx;
    logic [1:0]        byte_off;
  } mem_word_addr_t;

  // one address word, read as raw bytes or as index/offset
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    mem_word_addr_t    w;
  } mem_addr_t;

endpackage

`default_nettype wire

//--- rtl/streamer_pkg.sv
// ********************************************************************
// stream side definitions for the store streamer
// beat widths, pattern field width and controller states
// ********************************************************************
`default_nettype none

package streamer_pkg;

  localparam int unsigned STREAM_DW   = 32;          // stream beat
  localparam int unsigned STREAM_BE_W = STREAM_DW/8; // strobes per beat
  localparam int unsigned LEN_W       = 16;          // length / count fields

  // controller states
  typedef enum logic [1:0] {
    IDLE    = 2'b00, // waiting for start
    WORKING = 2'b01, // generator still issuing
    DRAIN   = 2'b10  // generator finished, sink catching up
  } streamer_state_t;

endpackage

`default_nettype wire

//--- rtl/store_addr_gen.sv
// ********************************************************************
// two-level address pattern generator
// one byte address per accepted push, rows restart on the outer stride
// ********************************************************************
`default_nettype none

module store_addr_gen #(
  parameter int unsigned TRANS_CNT = 16
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           clear_i,
  input  logic                           enable_i,
  input  logic                           start_i,
  input  logic [mem_pkg::ADDR_W-1:0]     base_addr_i,
  input  logic [streamer_pkg::LEN_W-1:0] tot_len_i,
  input  logic [streamer_pkg::LEN_W-1:0] d0_len_i,
  input  logic [mem_pkg::ADDR_W-1:0]     d0_stride_i,
  input  logic [mem_pkg::ADDR_W-1:0]     d1_stride_i,
  output mem_pkg::mem_addr_t             addr_o,
  output logic                           addr_valid_o,
  input  logic                           addr_ready_i,
  output logic                           finished_o
);

  logic                           active_q;    // pattern latched
  logic [TRANS_CNT-1:0]           trans_cnt_q; // accepted addresses
  logic [streamer_pkg::LEN_W-1:0] inner_cnt_q; // position in row
  mem_pkg::mem_addr_t             addr_q;
  logic [mem_pkg::ADDR_W-1:0]     outer_q;     // start of current row
  logic [streamer_pkg::LEN_W-1:0] tot_len_q;
  logic [streamer_pkg::LEN_W-1:0] d0_len_q;
  logic [mem_pkg::ADDR_W-1:0]     d0_stride_q;
  logic [mem_pkg::ADDR_W-1:0]     d1_stride_q;
  logic                           all_issued;
  logic                           push;
  logic                           row_end;

  assign all_issued   = (trans_cnt_q == TRANS_CNT'(tot_len_q));
  assign addr_valid_o = enable_i & active_q & ~all_issued; // frozen when disabled
  assign push         = addr_valid_o & addr_ready_i;
  assign row_end      = (inner_cnt_q == d0_len_q - 1'b1);  // last beat of a row
  assign addr_o       = addr_q;
  assign finished_o   = active_q & all_issued;

  // counters and activity
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q    <= 1'b0;
      trans_cnt_q <= '0;
      inner_cnt_q <= '0;
    end else if (clear_i) begin
      active_q    <= 1'b0;
      trans_cnt_q <= '0;
      inner_cnt_q <= '0;
    end else if (enable_i) begin
      if (start_i) begin
        active_q    <= 1'b1;
        trans_cnt_q <= '0;
        inner_cnt_q <= '0;
      end else if (push) begin
        trans_cnt_q <= trans_cnt_q + 1'b1;
        inner_cnt_q <= row_end ? '0 : inner_cnt_q + 1'b1;
      end
    end
  end

  // pattern fields and running address
  always_ff @(posedge clk_i) begin
    if (enable_i) begin
      if (start_i) begin
        tot_len_q   <= tot_len_i;
        d0_len_q    <= d0_len_i;
        d0_stride_q <= d0_stride_i;
        d1_stride_q <= d1_stride_i;
        outer_q     <= base_addr_i;
        addr_q.raw  <= base_addr_i; // first address offered next cycle
      end else if (push) begin
        if (row_end) begin
          // jump to the next row
          outer_q    <= outer_q + d1_stride_q;
          addr_q.raw <= outer_q + d1_stride_q;
        end else begin
          addr_q.raw <= addr_q.raw + d0_stride_q; // step inside the row
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/word_fifo.sv
// ********************************************************************
// circular FIFO with valid/ready push and pop, one cycle latency
// ********************************************************************
`default_nettype none

module word_fifo #(
  parameter int unsigned DATA_WIDTH = 32,
  parameter int unsigned DEPTH      = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  push_valid_i,
  input  logic [DATA_WIDTH-1:0] push_data_i,
  output logic                  push_ready_o,
  output logic                  pop_valid_o,
  output logic [DATA_WIDTH-1:0] pop_data_o,
  input  logic                  pop_ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [DATA_WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [CNT_W-1:0]      count_q; // occupancy
  logic                  push;
  logic                  pop;

  assign push_ready_o = (count_q != CNT_W'(DEPTH)); // low when full
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];
  assign push         = push_valid_i & push_ready_o;
  assign pop          = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1; // wrap
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

`default_nettype wire

//--- rtl/store_sink.sv
// ********************************************************************
// store sink: joins generated addresses with stream beats, aligns them
// into 64-bit words and issues them on the memory port
// ********************************************************************
`default_nettype none

module store_sink #(
  parameter int unsigned TRANS_CNT         = 16,
  parameter int unsigned MISALIGNED_ACCESS = 1,
  parameter int unsigned REQ_FIFO_DEPTH    = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 clear_i,
  input  logic                                 enable_i,
  input  logic                                 start_i,
  input  logic [mem_pkg::ADDR_W-1:0]           base_addr_i,
  input  logic [streamer_pkg::LEN_W-1:0]       tot_len_i,
  input  logic [streamer_pkg::LEN_W-1:0]       d0_len_i,
  input  logic [mem_pkg::ADDR_W-1:0]           d0_stride_i,
  input  logic [mem_pkg::ADDR_W-1:0]           d1_stride_i,
  input  logic                                 stream_valid_i,
  input  logic [streamer_pkg::STREAM_DW-1:0]   stream_data_i,
  input  logic [streamer_pkg::STREAM_BE_W-1:0] stream_strb_i,
  output logic                                 stream_ready_o,
  output logic                                 mem_req_o,
  output logic [mem_pkg::ADDR_W-1:0]           mem_addr_o,
  output logic [mem_pkg::MEM_DW-1:0]           mem_data_o,
  output logic [mem_pkg::MEM_BE_W-1:0]         mem_be_o,
  input  logic                                 mem_gnt_i,
  output logic                                 ready_start_o,
  output logic                                 done_o
);

  localparam int unsigned IDX_W = mem_pkg::ADDR_W - 2;
  localparam int unsigned REQ_W = IDX_W + mem_pkg::MEM_DW + mem_pkg::MEM_BE_W;
  localparam int unsigned PAD_D = mem_pkg::MEM_DW - streamer_pkg::STREAM_DW;
  localparam int unsigned PAD_B = mem_pkg::MEM_BE_W - streamer_pkg::STREAM_BE_W;

  streamer_pkg::streamer_state_t  state_q, state_d;
  logic                           gen_start, gen_clr, gen_finished;
  logic                           pattern_end; // drain complete
  mem_pkg::mem_addr_t             gen_addr, addr_pop;
  logic                           gen_valid, gen_ready;
  logic                           addr_pop_valid;
  logic                           busy;
  logic                           beat_ok;     // beat + address consumed
  logic [TRANS_CNT-1:0]           cnt_q;
  logic [streamer_pkg::LEN_W-1:0] tot_len_q;
  logic                           done_q;
  logic [mem_pkg::MEM_DW-1:0]     data_aligned;
  logic [mem_pkg::MEM_BE_W-1:0]   be_aligned;
  logic                           req_valid, req_ready;
  logic [REQ_W-1:0]               req_word, req_out;
  logic [IDX_W-1:0]               out_word_idx;

  assign gen_clr = clear_i | pattern_end;

  store_addr_gen #(
    .TRANS_CNT ( TRANS_CNT )
  ) i_addr_gen (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .clear_i      ( gen_clr      ),
    .enable_i     ( enable_i     ),
    .start_i      ( gen_start    ),
    .base_addr_i  ( base_addr_i  ),
    .tot_len_i    ( tot_len_i    ),
    .d0_len_i     ( d0_len_i     ),
    .d0_stride_i  ( d0_stride_i  ),
    .d1_stride_i  ( d1_stride_i  ),
    .addr_o       ( gen_addr     ),
    .addr_valid_o ( gen_valid    ),
    .addr_ready_i ( gen_ready    ),
    .finished_o   ( gen_finished )
  );

  // decouples generator from store path
  word_fifo #(
    .DATA_WIDTH ( mem_pkg::ADDR_W ),
    .DEPTH      ( 2               )
  ) i_addr_fifo (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .clear_i      ( clear_i        ),
    .push_valid_i ( gen_valid      ),
    .push_data_i  ( gen_addr       ),
    .push_ready_o ( gen_ready      ),
    .pop_valid_o  ( addr_pop_valid ),
    .pop_data_o   ( addr_pop       ),
    .pop_ready_i  ( beat_ok        )
  );

  // byte lane placement
  if (MISALIGNED_ACCESS != 0) begin : g_misaligned
    assign data_aligned = {{PAD_D{1'b0}}, stream_data_i} << {addr_pop.w.byte_off, 3'b000};
    assign be_aligned   = {{PAD_B{1'b0}}, stream_strb_i} << addr_pop.w.byte_off;
  end else begin : g_aligned
    assign data_aligned = {{PAD_D{1'b0}}, stream_data_i}; // lanes 0..3 only
    assign be_aligned   = {{PAD_B{1'b0}}, stream_strb_i};
  end

  // request gated off in IDLE and while frozen
  assign busy           = (state_q != streamer_pkg::IDLE) & enable_i;
  assign req_valid      = busy & stream_valid_i & addr_pop_valid;
  assign stream_ready_o = ~stream_valid_i | (busy & req_ready & addr_pop_valid);
  assign beat_ok        = stream_valid_i & stream_ready_o; // pops address too
  assign req_word       = {addr_pop.w.word_idx, data_aligned, be_aligned};

  if (REQ_FIFO_DEPTH > 0) begin : g_req_fifo
    word_fifo #(
      .DATA_WIDTH ( REQ_W          ),
      .DEPTH      ( REQ_FIFO_DEPTH )
    ) i_req_fifo (
      .clk_i        ( clk_i     ),
      .rst_ni       ( rst_ni    ),
      .clear_i      ( clear_i   ),
      .push_valid_i ( req_valid ),
      .push_data_i  ( req_word  ),
      .push_ready_o ( req_ready ),
      .pop_valid_o  ( mem_req_o ),
      .pop_data_o   ( req_out   ),
      .pop_ready_i  ( mem_gnt_i )
    );
  end else begin : g_req_direct
    assign mem_req_o = req_valid;
    assign req_ready = mem_gnt_i; // store goes straight to the port
    assign req_out   = req_word;
  end

  assign {out_word_idx, mem_data_o, mem_be_o} = req_out;
  assign mem_addr_o = {out_word_idx, 2'b00}; // word aligned

  // controller
  always_comb begin
    state_d     = state_q;
    gen_start   = 1'b0;
    pattern_end = 1'b0;
    case (state_q)
      streamer_pkg::IDLE: begin
        if (start_i) begin
          state_d   = streamer_pkg::WORKING;
          gen_start = 1'b1; // generator latches pattern now
        end
      end
      streamer_pkg::WORKING: begin
        if (gen_finished) state_d = streamer_pkg::DRAIN;
      end
      streamer_pkg::DRAIN: begin
        if (cnt_q == TRANS_CNT'(tot_len_q)) begin
          state_d     = streamer_pkg::IDLE;
          pattern_end = enable_i;
        end
      end
      default: state_d = streamer_pkg::IDLE;
    endcase
  end

  assign ready_start_o = (state_q == streamer_pkg::IDLE);
  assign done_o        = done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= streamer_pkg::IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else if (clear_i) begin
      state_q <= streamer_pkg::IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else if (enable_i) begin
      state_q <= state_d;
      done_q  <= pattern_end; // one-cycle pulse
      if (pattern_end) cnt_q <= '0;
      else if (beat_ok) cnt_q <= cnt_q + 1'b1; // consumed addresses
    end
  end

  // pattern length, compared during drain
  always_ff @(posedge clk_i) begin
    if (enable_i && gen_start) begin
      tot_len_q <= tot_len_i;
    end
  end

endmodule

`default_nettype wire

//--- rtl/store_streamer_top.sv
// ********************************************************************
// store streamer top level, sets the sink parameters
// ********************************************************************
`default_nettype none

module store_streamer_top #(
  parameter int unsigned TRANS_CNT         = 16,
  parameter int unsigned MISALIGNED_ACCESS = 1,
  parameter int unsigned REQ_FIFO_DEPTH    = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 clear_i,
  input  logic                                 enable_i,
  input  logic                                 start_i,
  input  logic [mem_pkg::ADDR_W-1:0]           base_addr_i,
  input  logic [streamer_pkg::LEN_W-1:0]       tot_len_i,
  input  logic [streamer_pkg::LEN_W-1:0]       d0_len_i,
  input  logic [mem_pkg::ADDR_W-1:0]           d0_stride_i,
  input  logic [mem_pkg::ADDR_W-1:0]           d1_stride_i,
  input  logic                                 stream_valid_i,
  input  logic [streamer_pkg::STREAM_DW-1:0]   stream_data_i,
  input  logic [streamer_pkg::STREAM_BE_W-1:0] stream_strb_i,
  output logic                                 stream_ready_o,
  output logic                                 mem_req_o,
  output logic [mem_pkg::ADDR_W-1:0]           mem_addr_o,
  output logic [mem_pkg::MEM_DW-1:0]           mem_data_o,
  output logic [mem_pkg::MEM_BE_W-1:0]         mem_be_o,
  input  logic                                 mem_gnt_i,
  output logic                                 ready_start_o,
  output logic                                 done_o
);

  store_sink #(
    .TRANS_CNT         ( TRANS_CNT         ),
    .MISALIGNED_ACCESS ( MISALIGNED_ACCESS ),
    .REQ_FIFO_DEPTH    ( REQ_FIFO_DEPTH    )
  ) i_sink (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .enable_i       ( enable_i       ),
    .start_i        ( start_i        ),
    .base_addr_i    ( base_addr_i    ),
    .tot_len_i      ( tot_len_i      ),
    .d0_len_i       ( d0_len_i       ),
    .d0_stride_i    ( d0_stride_i    ),
    .d1_stride_i    ( d1_stride_i    ),
    .stream_valid_i ( stream_valid_i ),
    .stream_data_i  ( stream_data_i  ),
    .stream_strb_i  ( stream_strb_i  ),
    .stream_ready_o ( stream_ready_o ),
    .mem_req_o      ( mem_req_o      ),
    .mem_addr_o     ( mem_addr_o     ),
    .mem_data_o     ( mem_data_o     ),
    .mem_be_o       ( mem_be_o       ),
    .mem_gnt_i      ( mem_gnt_i      ),
    .ready_start_o  ( ready_start_o  ),
    .done_o         ( done_o         )
  );

endmodule

`default_nettype wire

//--- verification/clk_gen.sv
// ********************************************************************
// testbench clock and power-on reset
// ********************************************************************
`default_nettype none

module clk_gen #(
  parameter int unsigned PERIOD     = 20,
  parameter int unsigned RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD/2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0; // held low for the first cycles
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

//--- verification/store_streamer_assert.sv
// ********************************************************************
// protocol checks for the store sink, bound into every instance
// ********************************************************************
`default_nettype none

module store_streamer_assert (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 mem_req_i,
  input  logic                                 mem_gnt_i,
  input  logic [mem_pkg::ADDR_W-1:0]           mem_addr_i,
  input  logic [mem_pkg::MEM_DW-1:0]           mem_data_i,
  input  logic [mem_pkg::MEM_BE_W-1:0]         mem_be_i,
  input  logic                                 stream_valid_i,
  input  logic                                 stream_ready_i,
  input  logic [streamer_pkg::STREAM_DW-1:0]   stream_data_i,
  input  logic [streamer_pkg::STREAM_BE_W-1:0] stream_strb_i,
  input  logic                                 done_i
);

  // pending store holds until granted
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_i && !mem_gnt_i) |=> (mem_req_i && $stable(mem_addr_i) &&
      $stable(mem_data_i) && $stable(mem_be_i)))
    else $error("memory request changed before its grant");

  // producer side, stalled beat must not move
  a_beat_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (stream_valid_i && !stream_ready_i) |=> (stream_valid_i &&
      $stable(stream_data_i) && $stable(stream_strb_i)))
    else $error("stream beat changed while stalled");

  // count hits tot_len after the last beat, done one edge later
  a_done_last_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |-> $past(stream_valid_i && stream_ready_i, 2))
    else $error("done without the last beat two cycles before");

endmodule

`default_nettype wire

//--- verification/tb_store_streamer.sv
// ********************************************************************
// store streamer testbench: random two-level patterns, byte memory
// model with random grant, results checked against the pattern rule
// ********************************************************************
`default_nettype none

module tb_store_streamer;

  localparam int unsigned NUM_TESTS   = 6;
  localparam int unsigned MAX_BEATS   = 32;
  localparam int unsigned CYCLE_LIMIT = NUM_TESTS * MAX_BEATS * 40; // 40 cycles per beat

  // named like the DUT ports so the instance connects with .*
  logic                                 clk_i;
  logic                                 rst_ni;
  logic                                 clear_i;
  logic                                 enable_i;
  logic                                 start_i;
  logic [mem_pkg::ADDR_W-1:0]           base_addr_i;
  logic [streamer_pkg::LEN_W-1:0]       tot_len_i;
  logic [streamer_pkg::LEN_W-1:0]       d0_len_i;
  logic [mem_pkg::ADDR_W-1:0]           d0_stride_i;
  logic [mem_pkg::ADDR_W-1:0]           d1_stride_i;
  logic                                 stream_valid_i;
  logic [streamer_pkg::STREAM_DW-1:0]   stream_data_i;
  logic [streamer_pkg::STREAM_BE_W-1:0] stream_strb_i;
  logic                                 stream_ready_o;
  logic                                 mem_req_o;
  logic [mem_pkg::ADDR_W-1:0]           mem_addr_o;
  logic [mem_pkg::MEM_DW-1:0]           mem_data_o;
  logic [mem_pkg::MEM_BE_W-1:0]         mem_be_o;
  logic                                 mem_gnt_i;
  logic                                 ready_start_o;
  logic                                 done_o;

  // current pattern and its beats
  int unsigned        pat_base, pat_tot, pat_d0_len, pat_d0, pat_d1;
  int unsigned        valid_pct, gnt_pct;
  bit                 bp_mode;      // long grant-low stretches
  string              test_name;
  logic [31:0]        beat_data [$];
  logic [3:0]         beat_strb [$];
  logic [31:0]        beat_addr [$];
  logic [7:0]         mem_model [int unsigned]; // what the DUT stored
  logic [7:0]         exp_mem [int unsigned];   // what it should store
  mem_pkg::mem_addr_t port_addr;
  int unsigned        done_total, store_total, strobed_total;
  int unsigned        err_cnt, check_cnt;
  int unsigned        cycles = 0;

  clk_gen i_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  store_streamer_top uut (.*);

  bind store_sink store_streamer_assert i_assert (
    .clk_i(clk_i), .rst_ni(rst_ni), .mem_req_i(mem_req_o), .mem_gnt_i(mem_gnt_i),
    .mem_addr_i(mem_addr_o), .mem_data_i(mem_data_o), .mem_be_i(mem_be_o),
    .stream_valid_i(stream_valid_i), .stream_ready_i(stream_ready_o),
    .stream_data_i(stream_data_i), .stream_strb_i(stream_strb_i),
    .done_i(done_o)
  );

  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a; // every address bit counts
  endfunction

  task automatic check_equal(input string sig, input logic [63:0] got, input logic [63:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("ERR %s: got 0x%0h, expected 0x%0h", sig, got, exp);
      err_cnt++;
    end
  endtask

  task automatic setup_pattern(input int unsigned test_no);
    int unsigned i;
    pat_tot    = $urandom_range(MAX_BEATS, 8);
    pat_d0_len = pat_tot;                        // one row by default
    pat_d0     = $urandom_range(12, 1);
    pat_d1     = pat_d0;
    pat_base   = 32'h1000 + $urandom_range(255); // any byte offset
    bp_mode    = 1'b0;
    gnt_pct    = $urandom_range(80, 50);
    valid_pct  = $urandom_range(90, 50);
    case (test_no)
      1: begin
        test_name = "aligned linear";
        pat_base  = pat_base & ~32'h3;
        pat_d0    = 4;
        pat_d1    = 4;
      end
      2: test_name = "misaligned strides";
      3: test_name = "partial strobes";
      4: begin
        test_name  = "two-level";
        pat_d0_len = $urandom_range(6, 2);
        pat_d1     = $urandom_range(64, 16);
      end
      5: test_name = "control";
      default: begin
        test_name  = "back-pressure";
        bp_mode    = 1'b1;
        pat_d0_len = $urandom_range(8, 2);
        pat_d1     = $urandom_range(48, 8);
      end
    endcase
    beat_data.delete();
    beat_strb.delete();
    for (i = 0; i < pat_tot; i++) begin
      beat_data.push_back($urandom());
      if (test_no <= 2) beat_strb.push_back(4'hf);
      else if (test_no == 5 && $urandom_range(3) == 0) beat_strb.push_back(4'h0); // empty beat
      else beat_strb.push_back(4'($urandom_range(15)));
    end
  endtask

  // walk the pattern rule, prefill a window around it, apply the beats in order
  task automatic build_expected();
    mem_pkg::mem_addr_t cur;
    logic [31:0]        row;
    int unsigned        inner, lo, hi, a, i, j;
    cur.raw = pat_base;
    row     = pat_base;
    inner   = 0;
    lo      = pat_base;
    hi      = pat_base;
    beat_addr.delete();
    for (i = 0; i < pat_tot; i++) begin
      beat_addr.push_back(cur.raw);
      if (cur.raw < lo) lo = cur.raw;
      if (cur.raw > hi) hi = cur.raw;
      if (inner == pat_d0_len - 1) begin
        row     = row + pat_d1; // next row from its own start
        cur.raw = row;
        inner   = 0;
      end else begin
        cur.raw = cur.raw + pat_d0;
        inner++;
      end
    end
    mem_model.delete();
    exp_mem.delete();
    for (a = lo - 4; a < hi + 8; a++) begin
      mem_model[a] = fill_byte(a);
      exp_mem[a]   = fill_byte(a);
    end
    for (i = 0; i < pat_tot; i++)
      for (j = 0; j < 4; j++)
        if (beat_strb[i][j]) exp_mem[beat_addr[i] + j] = beat_data[i][8*j +: 8];
  endtask

  // memory port model, grant source and event counters
  task automatic serve_memory();
    int unsigned lane;
    int unsigned stretch;
    logic        level;
    stretch = 0;
    level   = 1'b1;
    forever begin
      @(posedge clk_i);
      if (done_o) done_total++;
      if (mem_req_o && mem_gnt_i) begin
        port_addr.raw = mem_addr_o;
        store_total++;
        check_equal("mem_addr_o[1:0]", port_addr.w.byte_off, 2'b00); // port is word aligned
        if (mem_be_o != '0) strobed_total++;
        for (lane = 0; lane < mem_pkg::MEM_BE_W; lane++)
          if (mem_be_o[lane])
            mem_model[{port_addr.w.word_idx, 2'b00} + lane] = mem_data_o[8*lane +: 8];
      end
      if (!rst_ni) mem_gnt_i <= 1'b0;
      else if (bp_mode) begin
        if (stretch == 0) begin
          level   = ~level;
          stretch = level ? $urandom_range(4, 1) : $urandom_range(20, 5);
        end
        stretch--;
        mem_gnt_i <= level;
      end else mem_gnt_i <= ($urandom_range(99) < gnt_pct);
    end
  endtask

  task automatic drive_stream();
    int unsigned sent;
    bit          hold;
    sent = 0;
    while (sent < pat_tot) begin
      @(posedge clk_i);
      if (stream_valid_i && stream_ready_o) sent++; // beat taken at this edge
      hold = stream_valid_i && !stream_ready_o;
      if (!hold) begin
        if (sent < pat_tot && $urandom_range(99) < valid_pct) begin
          stream_valid_i <= 1'b1;
          stream_data_i  <= beat_data[sent];
          stream_strb_i  <= beat_strb[sent];
        end else stream_valid_i <= 1'b0;
      end
    end
  endtask

  task automatic watch_done();
    @(posedge clk_i);
    while (!done_o) begin
      check_equal("ready_start_o", ready_start_o, 1'b0); // busy until done
      @(posedge clk_i);
    end
  endtask

  task automatic compare_memory();
    int unsigned a;
    check_cnt++;
    assert (mem_model.size() == exp_mem.size()) else begin
      $display("memory holds %0d bytes instead of %0d, a store hit a wrong address",
               mem_model.size(), exp_mem.size());
      err_cnt++;
    end
    if (exp_mem.first(a)) begin
      do begin
        check_cnt++;
        assert (mem_model.exists(a)) else begin
          $display("byte at 0x%08h is missing from memory", a);
          err_cnt++;
        end
        if (mem_model.exists(a))
          check_equal($sformatf("mem_data_o byte @%08h", a), mem_model[a], exp_mem[a]);
      end while (exp_mem.next(a));
    end
  endtask

  task automatic run_pattern(input int unsigned test_no);
    int unsigned errs_before, done_before, stores_before, strobed_before;
    int unsigned strobed_exp, i;
    errs_before = err_cnt;
    build_expected();
    strobed_exp = 0;
    for (i = 0; i < pat_tot; i++)
      if (beat_strb[i] != 0) strobed_exp++;
    @(posedge clk_i);
    while (!ready_start_o) @(posedge clk_i);
    done_before    = done_total;
    stores_before  = store_total;
    strobed_before = strobed_total;
    start_i     <= 1'b1;
    base_addr_i <= pat_base;
    tot_len_i   <= 16'(pat_tot);
    d0_len_i    <= 16'(pat_d0_len);
    d0_stride_i <= pat_d0;
    d1_stride_i <= pat_d1;
    @(posedge clk_i);
    start_i <= 1'b0;       // sampled at this edge
    fork
      drive_stream();
      watch_done();
    join
    while (mem_req_o) @(posedge clk_i); // request buffer drains
    repeat (3) @(posedge clk_i);
    check_equal("done_o pulses", done_total - done_before, 1);
    check_equal("mem_req_o stores", store_total - stores_before, pat_tot);
    check_equal("mem_be_o strobed stores", strobed_total - strobed_before, strobed_exp);
    check_equal("ready_start_o", ready_start_o, 1'b1);
    compare_memory();
    $display("test %0d %-18s beats %0d: %0d errors", test_no, test_name, pat_tot,
             err_cnt - errs_before);
  endtask

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout, run not finished after %0d cycles", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    int unsigned t;
    void'($urandom(58));
    clear_i        = 1'b0;
    enable_i       = 1'b1;
    start_i        = 1'b0;
    base_addr_i    = '0;
    tot_len_i      = '0;
    d0_len_i       = '0;
    d0_stride_i    = '0;
    d1_stride_i    = '0;
    stream_valid_i = 1'b0;
    stream_data_i  = '0;
    stream_strb_i  = '0;
    mem_gnt_i      = 1'b0;
    fork
      serve_memory();
    join_none
    wait (rst_ni);
    for (t = 1; t <= NUM_TESTS; t++) begin
      setup_pattern(t);
      run_pattern(t);
    end
    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, check_cnt, err_cnt);
    if (err_cnt == 0) $display("RESULT: PASS");
    else $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
rtl/mem_pkg.sv
rtl/streamer_pkg.sv
rtl/store_addr_gen.sv
rtl/word_fifo.sv
rtl/store_sink.sv
rtl/store_streamer_top.sv
verification/clk_gen.sv
verification/store_streamer_assert.sv
verification/tb_store_streamer.sv

//--- run.sh
#!/usr/bin/env bash
# build the store streamer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_store_streamer -f flist.f \
  && ./obj_dir/Vtb_store_streamer | tee /dev/stderr | grep -q "^RESULT: PASS$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
